/* logic/interpDspPkg.sv */
// Interpolator datapath definitions
// Sample format, channel bundle, rate and CIC sizing, and the shared saturation rule
`default_nettype none

package interpDspPkg;

    localparam int sampleWidth = 18;
    localparam int numChannels = 4;
    localparam int interpRate = 4;
    localparam int cicOrder = 3;
    // The CIC output grows by log2 of its DC gain, interpRate**(cicOrder-1)
    localparam int cicGrowth = cicOrder * $clog2(interpRate) - $clog2(interpRate);

    // Widest intermediate value that satSample accepts
    localparam int wideWidth = 48;

    typedef logic signed [sampleWidth-1:0] sample_t;
    typedef logic signed [wideWidth-1:0] wide_t;

    localparam sample_t sampleMax = {1'b0, {(sampleWidth - 1){1'b1}}};
    localparam sample_t sampleMin = {1'b1, {(sampleWidth - 1){1'b0}}};

    typedef struct packed {
        sample_t [numChannels-1:0] ch;
    } channels_t;

    // Clip a wide signed value to the sample range
    function automatic sample_t satSample(input wide_t value);
        sample_t result;
        if (value > sampleMax) begin
            result = sampleMax;
        end else if (value < sampleMin) begin
            result = sampleMin;
        end else begin
            result = sample_t'(value);
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* logic/interpRegPkg.sv */
// Interpolator register map
// Word offsets on the host bus and the control bundle sent to the datapath
`default_nettype none

package interpRegPkg;

    localparam int regAddrWidth = 13;
    // Registers sit on 32-bit words, so the two byte address bits are ignored
    localparam int wordAddrWidth = regAddrWidth - 2;

    typedef logic [wordAddrWidth-1:0] wordAddr_t;

    localparam wordAddr_t ctrlAddr = 0;
    localparam wordAddr_t cicMantAddr = 1;
    localparam wordAddr_t cicExpAddr = 2;
    localparam wordAddr_t testAddr = 3;
    localparam wordAddr_t gainMantAddr = 4;
    localparam wordAddr_t gainExpAddr = 5;

    typedef struct packed {
        logic bypass;
        logic test;
        logic invert;
        // Stored and read back only, no equaliser is present
        logic bypassEq;
        logic [3:0] source;
        interpDspPkg::sample_t testValue;
        logic [4:0] cicExponent;
        logic [17:0] cicMantissa;
        logic [4:0] gainExponent;
        logic [15:0] gainMantissa;
    } interpCtrl_t;

endpackage

`default_nettype wire

/* logic/interpRegs.sv */
// Interpolator configuration registers
// Byte-lane writes on busClk, combinational readback that is zero when idle or unmapped
`timescale 1ns/100ps
`default_nettype none

module interpRegs (
    input  wire logic                                   busClk,
    input  wire logic                                   rstN,
    input  wire logic                                   cs,
    input  wire logic [3:0]                             wrEn,
    input  wire logic [interpRegPkg::regAddrWidth-1:0]  addr,
    input  wire logic [31:0]                            dataIn,
    output logic [31:0]                                 dataOut,
    output interpRegPkg::interpCtrl_t                   ctrl
);

    import interpRegPkg::*;

    wordAddr_t wordAddr;
    logic [31:0] readImage;
    logic [31:0] laneMask;
    logic [31:0] wrMerged;

    assign wordAddr = addr[regAddrWidth-1:2];
    assign laneMask = {{8{wrEn[3]}}, {8{wrEn[2]}}, {8{wrEn[1]}}, {8{wrEn[0]}}};

    // Disabled lanes keep the current register contents
    assign wrMerged = (readImage & ~laneMask) | (dataIn & laneMask);

    always_comb begin
        readImage = '0;
        case (wordAddr)
            ctrlAddr: begin
                readImage[0] = ctrl.bypass;
                readImage[1] = ctrl.test;
                readImage[2] = ctrl.invert;
                readImage[3] = ctrl.bypassEq;
                readImage[11:8] = ctrl.source;
            end
            cicMantAddr: readImage[17:0] = ctrl.cicMantissa;
            cicExpAddr: readImage[4:0] = ctrl.cicExponent;
            testAddr: readImage[17:0] = ctrl.testValue;
            gainMantAddr: readImage[31:16] = ctrl.gainMantissa;
            gainExpAddr: readImage[20:16] = ctrl.gainExponent;
            default: readImage = '0;
        endcase
    end

    assign dataOut = cs ? readImage : '0;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            ctrl <= '0;
        end else if (cs && (|wrEn)) begin
            case (wordAddr)
                ctrlAddr: begin
                    ctrl.bypass <= wrMerged[0];
                    ctrl.test <= wrMerged[1];
                    ctrl.invert <= wrMerged[2];
                    ctrl.bypassEq <= wrMerged[3];
                    ctrl.source <= wrMerged[11:8];
                end
                cicMantAddr: ctrl.cicMantissa <= wrMerged[17:0];
                cicExpAddr: ctrl.cicExponent <= wrMerged[4:0];
                testAddr: ctrl.testValue <= wrMerged[17:0];
                gainMantAddr: ctrl.gainMantissa <= wrMerged[31:16];
                gainExpAddr: ctrl.gainExponent <= wrMerged[20:16];
                default: ;
            endcase
        end
    end

    // An unknown select or address during a strobe would corrupt the whole map
    wrCtlKnown: assert property (@(posedge busClk) disable iff (!rstN)
        (|wrEn) |-> !$isunknown({cs, addr}));

endmodule

`default_nettype wire

/* logic/interpFrontEnd.sv */
// Interpolator front end
// Selects a channel or the test value, optionally negates it, and registers it
`timescale 1ns/100ps
`default_nettype none

module interpFrontEnd (
    input  wire logic                       busClk,
    input  wire logic                       rstN,
    input  wire interpRegPkg::interpCtrl_t  ctrl,
    input  wire interpDspPkg::channels_t    channelsIn,
    input  wire logic                       inValid,
    output interpDspPkg::sample_t           feSample,
    output logic                            feValid
);

    import interpDspPkg::*;

    sample_t selValue;
    sample_t feNext;

    // Source values past the last channel select silence
    always_comb begin
        selValue = '0;
        if (ctrl.test) begin
            selValue = ctrl.testValue;
        end else begin
            for (int i = 0; i < numChannels; i++) begin
                if (ctrl.source == i) begin
                    selValue = channelsIn.ch[i];
                end
            end
        end
    end

    // Negating the most negative sample clips to the positive limit
    assign feNext = ctrl.invert ? satSample(-wide_t'(selValue)) : selValue;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            feValid <= 1'b0;
        end else begin
            feValid <= inValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (inValid) begin
            feSample <= feNext;
        end
    end

endmodule

`default_nettype wire

/* logic/cicInterp.sv */
// CIC interpolator
// Combs at the input rate, zero-stuffed integrators at the output rate, and a bypass path
`timescale 1ns/100ps
`default_nettype none

module cicInterp #(
    parameter int rate = interpDspPkg::interpRate,
    parameter int order = interpDspPkg::cicOrder
) (
    input  wire logic                       busClk,
    input  wire logic                       rstN,
    input  wire interpRegPkg::interpCtrl_t  ctrl,
    input  wire interpDspPkg::sample_t      feSample,
    input  wire logic                       feValid,
    output interpDspPkg::sample_t           cicSample,
    output logic                            cicValid
);

    import interpDspPkg::*;

    localparam int growth = (order - 1) * $clog2(rate);
    localparam int accWidth = sampleWidth + growth;
    localparam int phaseWidth = (rate > 1) ? $clog2(rate) : 1;

    typedef logic signed [accWidth-1:0] acc_t;

    acc_t combDly [order];
    acc_t combTap [order+1];
    acc_t combOut;
    acc_t integ [order];
    acc_t integNext [order];
    acc_t integIn;
    logic [phaseWidth-1:0] phase;
    logic busy;
    logic lastPhase;
    logic runCic;
    logic satHit;
    logic inRange;
    logic [order-1:0] inRangeHist;

    assign runCic = feValid && !ctrl.bypass;
    assign lastPhase = (phase == phaseWidth'(rate - 1));

    // Wraparound arithmetic is safe here since the final sum always fits accWidth
    always_comb begin
        combTap[0] = feSample;
        for (int k = 0; k < order; k++) begin
            combTap[k+1] = combTap[k] - combDly[k];
        end
    end

    // Only phase 0 carries the comb output, the other slots are stuffed zeros
    always_comb begin
        integIn = (phase == '0) ? combOut : '0;
        integNext[0] = integ[0] + integIn;
        for (int k = 1; k < order; k++) begin
            integNext[k] = integ[k] + integNext[k-1];
        end
    end

    assign satHit = (satSample(integNext[order-1]) != integNext[order-1]);
    assign inRange = (feSample[sampleWidth-1 -: growth+1] == '0) ||
                     (feSample[sampleWidth-1 -: growth+1] == '1);

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            phase <= '0;
        end else if (runCic) begin
            busy <= 1'b1;
            phase <= '0;
        end else if (busy) begin
            busy <= !lastPhase;
            phase <= lastPhase ? '0 : phase + 1'b1;
        end
    end

    // Filter state freezes while bypass is on
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < order; k++) begin
                combDly[k] <= '0;
                integ[k] <= '0;
            end
            combOut <= '0;
            inRangeHist <= '1;
        end else begin
            if (runCic) begin
                for (int k = 0; k < order; k++) begin
                    combDly[k] <= combTap[k];
                end
                combOut <= combTap[order];
                inRangeHist[0] <= inRange;
                for (int k = 1; k < order; k++) begin
                    inRangeHist[k] <= inRangeHist[k-1];
                end
            end
            if (busy) begin
                for (int k = 0; k < order; k++) begin
                    integ[k] <= integNext[k];
                end
            end
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            cicValid <= 1'b0;
        end else begin
            cicValid <= ctrl.bypass ? feValid : busy;
        end
    end

    always_ff @(posedge busClk) begin
        if (ctrl.bypass) begin
            cicSample <= feSample;
        end else if (busy) begin
            cicSample <= satSample(integNext[order-1]);
        end
    end

    // A new sample may only land on the last slot of the running burst
    burstSpacing: assert property (@(posedge busClk) disable iff (!rstN)
        (feValid && busy) |-> lastPhase);

    // Each output depends on the last order inputs, so in-range history rules out clipping
    noIntegSat: assert property (@(posedge busClk) disable iff (!rstN)
        (busy && (&inRangeHist)) |-> !satHit);

endmodule

`default_nettype wire

/* logic/interpScaler.sv */
// Mantissa and exponent gain stage
// Unsigned mantissa multiply, then arithmetic right shift with saturation
`timescale 1ns/100ps
`default_nettype none

module interpScaler #(
    parameter int mantWidth = 16
) (
    input  wire logic                   busClk,
    input  wire logic                   rstN,
    input  wire interpDspPkg::sample_t  sampleIn,
    input  wire logic                   inValid,
    input  wire logic [mantWidth-1:0]   mantissa,
    input  wire logic [4:0]             exponent,
    output interpDspPkg::sample_t       sampleOut,
    output logic                        outValid
);

    import interpDspPkg::*;

    localparam int prodWidth = sampleWidth + mantWidth + 1;

    typedef logic signed [prodWidth-1:0] prod_t;

    prod_t product;
    prod_t shifted;
    logic prodValid;

    assign shifted = product >>> exponent;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            prodValid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            prodValid <= inValid;
            outValid <= prodValid;
        end
    end

    // Mantissa is unsigned, so it gets a zero sign bit before the multiply
    always_ff @(posedge busClk) begin
        if (inValid) begin
            product <= prod_t'(sampleIn) * prod_t'($signed({1'b0, mantissa}));
        end
        if (prodValid) begin
            sampleOut <= satSample(shifted);
        end
    end

    // Every accepted sample leaves two cycles later carrying defined data
    fixedLatency: assert property (@(posedge busClk) disable iff (!rstN)
        inValid |-> ##2 (outValid && !$isunknown(sampleOut)));

endmodule

`default_nettype wire

/* logic/interpTop.sv */
// Interpolator stage top level
// Registers, front end, CIC, gain normalisation and user gain in a single chain
`timescale 1ns/100ps
`default_nettype none

module interpTop (
    input  wire logic                                   busClk,
    input  wire logic                                   rstN,
    input  wire logic                                   cs,
    input  wire logic [3:0]                             wrEn,
    input  wire logic [interpRegPkg::regAddrWidth-1:0]  addr,
    input  wire logic [31:0]                            dataIn,
    input  wire interpDspPkg::channels_t                channelsIn,
    input  wire logic                                   inValid,
    output logic [31:0]                                 dataOut,
    output interpDspPkg::sample_t                       sampleOut,
    output logic                                        outValid
);

    import interpDspPkg::*;
    import interpRegPkg::*;

    interpCtrl_t ctrl;
    sample_t feSample;
    sample_t cicSample;
    sample_t normSample;
    logic feValid;
    logic cicValid;
    logic normValid;

    interpRegs i_interpRegs (
        .busClk  (busClk),
        .rstN    (rstN),
        .cs      (cs),
        .wrEn    (wrEn),
        .addr    (addr),
        .dataIn  (dataIn),
        .dataOut (dataOut),
        .ctrl    (ctrl)
    );

    interpFrontEnd i_interpFrontEnd (
        .busClk     (busClk),
        .rstN       (rstN),
        .ctrl       (ctrl),
        .channelsIn (channelsIn),
        .inValid    (inValid),
        .feSample   (feSample),
        .feValid    (feValid)
    );

    cicInterp i_cicInterp (
        .busClk    (busClk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .feSample  (feSample),
        .feValid   (feValid),
        .cicSample (cicSample),
        .cicValid  (cicValid)
    );

    // Removes the CIC DC gain
    interpScaler #(.mantWidth(18)) cicNorm (
        .busClk    (busClk),
        .rstN      (rstN),
        .sampleIn  (cicSample),
        .inValid   (cicValid),
        .mantissa  (ctrl.cicMantissa),
        .exponent  (ctrl.cicExponent),
        .sampleOut (normSample),
        .outValid  (normValid)
    );

    interpScaler #(.mantWidth(16)) userGain (
        .busClk    (busClk),
        .rstN      (rstN),
        .sampleIn  (normSample),
        .inValid   (normValid),
        .mantissa  (ctrl.gainMantissa),
        .exponent  (ctrl.gainExponent),
        .sampleOut (sampleOut),
        .outValid  (outValid)
    );

endmodule

`default_nettype wire

/* verification/interpTb.sv */
// Testbench for the interpolator stage
// Drives the host bus and the sample input, predicts results and checks them with assertions
`timescale 1ns/100ps
`default_nettype none

module interpTb;

    import interpDspPkg::*;
    import interpRegPkg::*;

    localparam int numRegs = 6;
    localparam int waitLimit = 200;
    localparam int cicGain = interpRate ** (cicOrder - 1);
    // Outputs after a setting change that may still hold older input samples
    localparam int settleOut = 4 * interpRate;
    localparam int dcInputs = 8;

    logic busClk;
    logic rstN;
    logic cs;
    logic [3:0] wrEn;
    logic [regAddrWidth-1:0] addr;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    channels_t channelsIn;
    logic inValid;
    sample_t sampleOut;
    logic outValid;

    logic [31:0] shadow [numRegs];
    logic readCheck;
    logic [31:0] readExpect;
    logic countCheck;
    int countExpect;
    logic valueArmed;
    sample_t expSample;
    int skipOut;
    int outBase;
    int outCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    logic hung;

    interpTop i_interpTop (
        .busClk     (busClk),
        .rstN       (rstN),
        .cs         (cs),
        .wrEn       (wrEn),
        .addr       (addr),
        .dataIn     (dataIn),
        .channelsIn (channelsIn),
        .inValid    (inValid),
        .dataOut    (dataOut),
        .sampleOut  (sampleOut),
        .outValid   (outValid)
    );

    initial begin
        busClk = 1'b0;
        forever #5 busClk = ~busClk;
    end

    always @(posedge busClk) begin
        if (outValid) begin
            outCount <= outCount + 1;
        end
        if (readCheck || countCheck ||
            (outValid && valueArmed && (outCount - outBase) >= skipOut)) begin
            checkCount <= checkCount + 1;
        end
    end

    readbackOk: assert property (@(posedge busClk) readCheck |-> dataOut == readExpect)
        else begin
            errorCount = errorCount + 1;
            $display("Fail at %0t: register read returned %h, expected %h", $time,
                $sampled(dataOut), $sampled(readExpect));
        end

    sampleOk: assert property (@(posedge busClk) disable iff (!rstN)
        (outValid && valueArmed && (outCount - outBase) >= skipOut) |-> sampleOut == expSample)
        else begin
            errorCount = errorCount + 1;
            $display("Fail at %0t: output sample %0d, expected %0d", $time,
                $sampled(sampleOut), $sampled(expSample));
        end

    countOk: assert property (@(posedge busClk) countCheck |-> (outCount - outBase) == countExpect)
        else begin
            errorCount = errorCount + 1;
            $display("Fail at %0t: %0d output samples, expected %0d", $time,
                $sampled(outCount - outBase), $sampled(countExpect));
        end

    function automatic longint clipToSample(input longint value);
        longint maxValue;
        maxValue = (longint'(1) << (sampleWidth - 1)) - 1;
        if (value > maxValue) begin
            return maxValue;
        end else if (value < -maxValue - 1) begin
            return -maxValue - 1;
        end
        return value;
    endfunction

    // Unsigned mantissa product, arithmetic shift, then clip
    function automatic longint scaleRef(input longint value, input longint mant, input int shift);
        return clipToSample((value * mant) >>> shift);
    endfunction

    function automatic sample_t frontRef(input channels_t chVal, input logic [3:0] source,
                                         input logic invert);
        longint value;
        value = 0;
        if (source < numChannels) begin
            value = $signed(chVal.ch[source]);
        end
        if (invert) begin
            value = clipToSample(-value);
        end
        return sample_t'(value);
    endfunction

    // Readable bits of each register in the map
    function automatic logic [31:0] fieldMask(input int offset);
        case (offset)
            0: return 32'h0000_0f0f;
            1: return 32'h0003_ffff;
            2: return 32'h0000_001f;
            3: return 32'h0003_ffff;
            4: return 32'hffff_0000;
            5: return 32'h001f_0000;
            default: return 32'h0;
        endcase
    endfunction

    task automatic busWrite(input int offset, input logic [3:0] lanes, input logic [31:0] data);
        logic [31:0] laneBits;
        laneBits = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        @(posedge busClk);
        cs <= 1'b1;
        wrEn <= lanes;
        addr <= regAddrWidth'(offset * 4);
        dataIn <= data;
        @(posedge busClk);
        cs <= 1'b0;
        wrEn <= 4'h0;
        if (offset < numRegs) begin
            shadow[offset] = ((shadow[offset] & ~laneBits) | (data & laneBits)) & fieldMask(offset);
        end
    endtask

    task automatic busRead(input int offset, input logic chipSel, input logic [31:0] expValue);
        @(posedge busClk);
        cs <= chipSel;
        wrEn <= 4'h0;
        addr <= regAddrWidth'(offset * 4);
        readExpect <= expValue;
        readCheck <= 1'b1;
        @(posedge busClk);
        cs <= 1'b0;
        readCheck <= 1'b0;
    endtask

    task automatic writeConfig(input logic bypass, input logic test, input logic invert,
                               input logic [3:0] source, input sample_t testValue,
                               input logic [17:0] cicMant, input logic [4:0] cicExp,
                               input logic [15:0] gainMant, input logic [4:0] gainExp);
        busWrite(int'(ctrlAddr), 4'hf, {20'h0, source, 5'h0, invert, test, bypass});
        busWrite(int'(cicMantAddr), 4'hf, {14'h0, cicMant});
        busWrite(int'(cicExpAddr), 4'hf, {27'h0, cicExp});
        busWrite(int'(testAddr), 4'hf, {14'h0, testValue});
        busWrite(int'(gainMantAddr), 4'hf, {gainMant, 16'h0});
        busWrite(int'(gainExpAddr), 4'hf, {11'h0, gainExp, 16'h0});
    endtask

    // Input pulses go out at the tightest legal spacing
    task automatic sendSample(input channels_t chVal);
        @(posedge busClk);
        channelsIn <= chVal;
        inValid <= 1'b1;
        @(posedge busClk);
        inValid <= 1'b0;
        repeat (interpRate - 2) @(posedge busClk);
    endtask

    task automatic startWindow(input logic armValue, input sample_t value, input int skip);
        @(posedge busClk);
        outBase <= outCount;
        valueArmed <= armValue;
        expSample <= value;
        skipOut <= skip;
    endtask

    task automatic waitOutputs(input int target);
        int cycles;
        cycles = 0;
        while (!hung && (outCount - outBase) < target) begin
            @(posedge busClk);
            cycles++;
            if (cycles > waitLimit) begin
                hung = 1'b1;
                $display("Timeout at %0t: only %0d of %0d output samples arrived", $time,
                    outCount - outBase, target);
            end
        end
    endtask

    // Idles long enough for any extra output to show up before the count is checked
    task automatic checkOutputs(input int target);
        waitOutputs(target);
        repeat (2 * interpRate + 8) @(posedge busClk);
        countExpect <= target;
        countCheck <= 1'b1;
        @(posedge busClk);
        countCheck <= 1'b0;
        valueArmed <= 1'b0;
    endtask

    task automatic reportTest(input string name, input int errStart);
        @(posedge busClk);
        $display("%s: %0d errors", name, errorCount - errStart);
    endtask

    function automatic channels_t randomChannels();
        channels_t chVal;
        for (int c = 0; c < numChannels; c++) begin
            chVal.ch[c] = sample_t'($urandom);
        end
        return chVal;
    endfunction

    task automatic testReadback();
        for (int r = 0; r < numRegs; r++) begin
            busWrite(r, 4'hf, $urandom);
        end
        for (int r = 0; r < numRegs; r++) begin
            busRead(r, 1'b1, shadow[r]);
            busRead(r, 1'b0, 32'h0);
        end
        busWrite(6, 4'hf, $urandom);
        busRead(6, 1'b1, 32'h0);
        busRead(7, 1'b1, 32'h0);
        busRead(2047, 1'b1, 32'h0);
        for (int r = 0; r < numRegs; r++) begin
            busRead(r, 1'b1, shadow[r]);
        end
    endtask

    task automatic testByteLanes();
        for (int r = 0; r < numRegs; r++) begin
            for (int lane = 0; lane < 4; lane++) begin
                busWrite(r, 4'(1 << lane), $urandom);
                busRead(r, 1'b1, shadow[r]);
            end
        end
    endtask

    task automatic testBypass();
        channels_t chVal;
        for (int src = 0; src < 6; src++) begin
            for (int inv = 0; inv < 2; inv++) begin
                writeConfig(1'b1, 1'b0, inv[0], src[3:0], '0, 18'd1, 5'd0, 16'd1, 5'd0);
                chVal = randomChannels();
                // Channel 1 carries the value whose negation has to clip
                chVal.ch[1] = sampleMin;
                startWindow(1'b1, frontRef(chVal, src[3:0], inv[0]), 0);
                sendSample(chVal);
                checkOutputs(1);
            end
        end
    endtask

    task automatic testRate();
        writeConfig(1'b0, 1'b0, 1'b0, 4'd0, '0, 18'd1, 5'd4, 16'd1, 5'd0);
        startWindow(1'b0, '0, 0);
        repeat (5) sendSample(randomChannels());
        checkOutputs(5 * interpRate);
    endtask

    task automatic dcTrial(input sample_t level, input logic [17:0] cicMant,
                           input logic [4:0] cicExp, input logic [15:0] gainMant,
                           input logic [4:0] gainExp);
        longint cicLevel;
        sample_t expValue;
        cicLevel = clipToSample(longint'(level) * cicGain);
        expValue = sample_t'(scaleRef(scaleRef(cicLevel, cicMant, cicExp), gainMant, gainExp));
        writeConfig(1'b0, 1'b1, 1'b0, 4'd0, level, cicMant, cicExp, gainMant, gainExp);
        startWindow(1'b1, expValue, settleOut);
        repeat (dcInputs) sendSample(channelsIn);
        checkOutputs(dcInputs * interpRate);
    endtask

    initial begin
        int errStart;
        void'($urandom(32'hf941));
        rstN = 1'b0;
        cs = 1'b0;
        wrEn = 4'h0;
        addr = '0;
        dataIn = 32'h0;
        channelsIn = '0;
        inValid = 1'b0;
        readCheck = 1'b0;
        readExpect = 32'h0;
        countCheck = 1'b0;
        countExpect = 0;
        valueArmed = 1'b0;
        expSample = '0;
        skipOut = 0;
        outBase = 0;
        hung = 1'b0;
        for (int r = 0; r < numRegs; r++) begin
            shadow[r] = 32'h0;
        end
        repeat (3) @(posedge busClk);
        rstN <= 1'b1;

        errStart = errorCount;
        testReadback();
        reportTest("register readback", errStart);
        errStart = errorCount;
        testByteLanes();
        reportTest("byte-lane writes", errStart);
        errStart = errorCount;
        testBypass();
        reportTest("bypass source select and invert", errStart);
        errStart = errorCount;
        testRate();
        reportTest("interpolation rate", errStart);

        errStart = errorCount;
        dcTrial(sample_t'(1234), 18'd1, 5'd4, 16'd1, 5'd0);
        dcTrial(sample_t'(-777), 18'd1, 5'd4, 16'd1, 5'd0);
        dcTrial(sample_t'(8191), 18'd1, 5'd4, 16'd1, 5'd0);
        reportTest("CIC DC gain", errStart);

        errStart = errorCount;
        dcTrial(sample_t'(6000), 18'd1, 5'd4, 16'hffff, 5'd0);
        dcTrial(sample_t'(-6000), 18'd1, 5'd4, 16'hffff, 5'd0);
        // The CIC itself clips here before normalisation
        dcTrial(sample_t'(100000), 18'd1, 5'd4, 16'd1, 5'd0);
        repeat (4) begin
            dcTrial(sample_t'(int'($urandom_range(16383)) - 8192), 18'($urandom_range(40, 1)),
                5'($urandom_range(8)), 16'($urandom_range(3000, 1)), 5'($urandom_range(12)));
        end
        reportTest("gain scaling and saturation", errStart);

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, hung);
        if (hung || errorCount != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/interpDspPkg.sv
logic/interpRegPkg.sv
logic/interpRegs.sv
logic/interpFrontEnd.sv
logic/cicInterp.sv
logic/interpScaler.sv
logic/interpTop.sv
verification/interpTb.sv

/* run.sh */
#!/bin/sh
# Builds the interpolator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
buildLog=build.log
simLog=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module interpTb -Mdir "$buildDir" -f vlog.f > "$buildLog" 2>&1
buildStatus=$?
cat "$buildLog"
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/VinterpTb" > "$simLog" 2>&1
simStatus=$?
cat "$simLog"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test FAILED" "$simLog"; then
    echo "Simulation reported failing checks"
    exit 1
fi

exit 0
